//--- hazard_ctrl_settings.svh
`ifndef HAZARD_CTRL_SETTINGS_SVH
`define HAZARD_CTRL_SETTINGS_SVH

// completion buffer sizing
// depth must stay a power of two so the tag pointers wrap on their own
`define CB_DEPTH 8

// tag width, log2 of the depth
`define CB_TAG_W 3

// architectural integer registers of rv32
`define NUM_REGS 32

`endif

//--- ooo_core_pkg.sv
package ooo_core_pkg;

  // functional unit selected by decode
  typedef enum logic [1:0] {
    ARITH_S,
    MUL_S,
    DIV_S,
    LOADSTORE_S
  } fu_type_t;

  // exception cause reported at writeback
  // none means the instruction retires normally
  typedef enum logic [3:0] {
    none,
    mal_insn,
    fault_insn,
    illegal_insn,
    mal_l,
    mal_s,
    fault_l,
    fault_s,
    breakpoint,
    env_m
  } exc_cause_t;

  // one reorder slot
  typedef struct packed {
    logic       valid;
    logic       done;
    logic [4:0] rd;
    logic       wen;
    logic [31:0] pc;
    exc_cause_t cause;
  } cb_entry_t;

endpackage

//--- hazard_if.sv
interface hazard_if;

  // decode stage operands
  logic [4:0] rs1;
  logic [4:0] rs2;
  logic [4:0] rd;
  logic       wen;
  // operand source selects, 0 and 1 read the register file
  logic [1:0] source_a_sel;
  logic [1:0] source_b_sel;

  // pending lookups from the scoreboard
  logic rs1_busy;
  logic rs2_busy;
  logic rd_busy;

  // decode instruction accepted this cycle
  logic dispatch;

  modport scoreboard (
    input  rs1, rs2, rd, wen, dispatch,
    output rs1_busy, rs2_busy, rd_busy
  );

  modport hazard_unit (
    input  wen, source_a_sel, source_b_sel, rs1_busy, rs2_busy, rd_busy,
    output dispatch
  );

  modport top (
    output rs1, rs2, rd, wen, source_a_sel, source_b_sel
  );

endinterface

//--- completion_if.sv
interface completion_if;
  import ooo_core_pkg::*;

  // precise flush from an excepting head
  logic        flush;
  logic [31:0] epc;
  exc_cause_t  cause;
  // occupancy
  logic        full;
  logic        empty;
  // in-order retire
  logic        commit_valid;
  logic [4:0]  commit_rd;
  // allocation request from the hazard unit
  logic        dispatch;

  modport cb (
    input  dispatch,
    output flush, epc, cause, full, empty, commit_valid, commit_rd
  );

  modport hu (
    input  flush, cause, full, empty,
    output dispatch
  );

endinterface

//--- reg_scoreboard.sv
`include "hazard_ctrl_settings.svh"

module reg_scoreboard (
  input  logic       CLK,
  input  logic       arst_n,
  hazard_if.scoreboard hz,
  input  logic       commit_valid,
  input  logic [4:0] commit_rd,
  input  logic       flush
);

  // one bit per register, high while a result is outstanding
  logic [`NUM_REGS-1:0] pending;
  logic [`NUM_REGS-1:0] pending_nxt;

  // lookups for the decode operands
  assign hz.rs1_busy = pending[hz.rs1];
  assign hz.rs2_busy = pending[hz.rs2];
  assign hz.rd_busy  = pending[hz.rd];

  always_comb begin
    pending_nxt = pending;
    // retire first so a new writer of the same register wins
    if (commit_valid) begin
      pending_nxt[commit_rd] = 1'b0;
    end
    // x0 is hardwired, never wait on it
    if (hz.dispatch && hz.wen && (hz.rd != 5'd0)) begin
      pending_nxt[hz.rd] = 1'b1;
    end
    // precise exception drops every in-flight writer
    if (flush) begin
      pending_nxt = '0;
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      pending <= '0;
    end else begin
      pending <= pending_nxt;
    end
  end

  a_x0_never_pending: assert property (@(posedge CLK) disable iff (!arst_n)
    !pending[0])
    else $error("x0 marked pending");

  // the buffer only retires a register that this block saw dispatched
  a_commit_was_pending: assert property (@(posedge CLK) disable iff (!arst_n)
    (commit_valid && (commit_rd != 5'd0)) |-> pending[commit_rd])
    else $error("commit of register %0d with no pending write", commit_rd);

endmodule

//--- completion_buffer.sv
`include "hazard_ctrl_settings.svh"

module completion_buffer (
  input  logic                     CLK,
  input  logic                     arst_n,
  completion_if.cb                 cb,
  input  logic [4:0]               rd,
  input  logic                     wen,
  input  logic [31:0]              pc_fe,
  input  logic                     wb_valid,
  input  logic [`CB_TAG_W-1:0]     wb_tag,
  input  ooo_core_pkg::exc_cause_t wb_cause,
  output logic [`CB_TAG_W-1:0]     issue_tag
);
  import ooo_core_pkg::*;

  cb_entry_t q [`CB_DEPTH];

  // head retires, tail allocates
  logic [`CB_TAG_W-1:0] head;
  logic [`CB_TAG_W-1:0] tail;
  // one extra bit to tell full from empty
  logic [`CB_TAG_W:0]   count;

  cb_entry_t head_e;
  logic      head_exc;

  assign head_e   = q[head];
  assign head_exc = head_e.valid & head_e.done & (head_e.cause != none);

  // retire only clean completions
  assign cb.commit_valid = head_e.valid & head_e.done & (head_e.cause == none);
  // non-writers retire as x0 so they never clear another writer's bit
  assign cb.commit_rd    = head_e.wen ? head_e.rd : 5'd0;

  // excepting head, flush in the same cycle
  assign cb.flush = head_exc;
  assign cb.epc   = head_e.pc;
  assign cb.cause = head_exc ? head_e.cause : none;

  assign cb.full  = (count == `CB_DEPTH);
  assign cb.empty = (count == '0);

  // tag handed out with the dispatch
  assign issue_tag = tail;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      for (int i = 0; i < `CB_DEPTH; i++) begin
        q[i] <= '0;
      end
    end else if (head_exc) begin
      // drop everything, younger entries included
      head  <= '0;
      tail  <= '0;
      count <= '0;
      for (int i = 0; i < `CB_DEPTH; i++) begin
        q[i].valid <= 1'b0;
        q[i].done  <= 1'b0;
      end
    end else begin
      // writeback can land in any order
      if (wb_valid) begin
        q[wb_tag].done  <= 1'b1;
        q[wb_tag].cause <= wb_cause;
      end
      if (cb.dispatch) begin
        q[tail] <= '{valid: 1'b1, done: 1'b0, rd: rd, wen: wen, pc: pc_fe, cause: none};
        tail    <= tail + 1'b1;
      end
      if (cb.commit_valid) begin
        q[head].valid <= 1'b0;
        q[head].done  <= 1'b0;
        head          <= head + 1'b1;
      end
      case ({cb.dispatch, cb.commit_valid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the hazard unit must hold decode while full
  a_no_dispatch_full: assert property (@(posedge CLK) disable iff (!arst_n)
    cb.dispatch |-> !cb.full)
    else $error("dispatch into a full completion buffer");

  a_wb_to_valid: assert property (@(posedge CLK) disable iff (!arst_n)
    (wb_valid && !head_exc) |-> q[wb_tag].valid)
    else $error("writeback to unallocated tag %0d", wb_tag);

endmodule

//--- ooo_hazard_unit.sv
module ooo_hazard_unit (
  hazard_if.hazard_unit   hz,
  completion_if.hu        cb,
  input  logic            dec_valid,
  input  ooo_core_pkg::fu_type_t fu_type,
  input  logic            csr,
  input  logic            ifence,
  input  logic            busy_du,
  input  logic            busy_ls,
  input  logic            i_mem_busy,
  input  logic            mispredict,
  input  logic            intr_req,
  input  logic            insert_pc,
  output logic            pc_en,
  output logic            stall_fetch_decode,
  output logic            fetch_decode_flush,
  output logic            decode_execute_flush,
  output logic            execute_commit_flush,
  output logic            npc_sel,
  output logic            pipe_clear,
  output logic            intr_taken,
  output logic            wb_enable
);
  import ooo_core_pkg::*;

  logic rs1_hz;
  logic rs2_hz;
  logic rd_hz;
  logic data_hazard;
  logic structural_hazard;
  logic store;
  logic serial_wait;
  logic intr;
  logic stall_au;
  logic stall_ex;
  logic csr_flush;
  logic update_pc_wait_ihit;

  // selects 2 and 3 are imm/pc, no register read
  assign rs1_hz = (hz.source_a_sel <= 2'd1) & hz.rs1_busy;
  assign rs2_hz = (hz.source_b_sel <= 2'd1) & hz.rs2_busy;
  // waw, one writer per register at a time
  assign rd_hz  = hz.rd_busy & hz.wen;

  assign data_hazard = dec_valid & (rs1_hz | rs2_hz | rd_hz);

  // single divider and single load/store port
  assign structural_hazard = dec_valid &
                             (((fu_type == DIV_S) & busy_du) |
                              ((fu_type == LOADSTORE_S) & busy_ls));

  // store decodes with source a select 1
  assign store       = (fu_type == LOADSTORE_S) & (hz.source_a_sel == 2'd1);
  // stores and ifence drain the buffer first
  assign serial_wait = dec_valid & (store | ifence) & ~cb.empty;

  // no interrupt on top of a precise exception
  assign intr       = intr_req & (cb.cause == none);
  assign intr_taken = intr & cb.empty;

  // csr serializes through the arithmetic unit
  assign stall_au  = csr;
  assign csr_flush = csr;

  // older exception outranks a younger mispredict
  assign npc_sel = mispredict & ~cb.flush;

  // redirect has to wait for the outstanding fetch
  assign update_pc_wait_ihit = (npc_sel | csr_flush | insert_pc | intr_taken) & i_mem_busy;
  assign stall_ex            = cb.full | update_pc_wait_ihit;

  assign stall_fetch_decode = intr | stall_au | stall_ex | data_hazard |
                              structural_hazard | serial_wait;

  assign hz.dispatch = dec_valid & ~stall_fetch_decode;
  assign cb.dispatch = hz.dispatch;

  always_comb begin
    // fetch stalls for imem as well as decode
    pc_en = ~(i_mem_busy | stall_fetch_decode);
    assert (!(pc_en && data_hazard))
      else $error("pc advanced over a data hazard");
  end

  // flush levels
  assign fetch_decode_flush   = npc_sel | insert_pc | csr_flush | cb.flush;
  // held off while a fetch is still in flight
  assign decode_execute_flush = (npc_sel | insert_pc | cb.flush) & ~i_mem_busy;
  assign execute_commit_flush = csr_flush | cb.flush;

  // privilege block notifications
  assign pipe_clear = intr ? (cb.empty & ~i_mem_busy) : (cb.flush & ~i_mem_busy);
  assign wb_enable  = ~stall_fetch_decode & ~npc_sel;

endmodule

//--- hazard_ctrl_top.sv
`include "hazard_ctrl_settings.svh"

module hazard_ctrl_top (
  input  logic                     CLK,
  input  logic                     arst_n,
  // decode
  input  logic                     dec_valid,
  input  logic [4:0]               rs1,
  input  logic [4:0]               rs2,
  input  logic [4:0]               rd,
  input  logic                     wen,
  input  logic [1:0]               source_a_sel,
  input  logic [1:0]               source_b_sel,
  input  ooo_core_pkg::fu_type_t   fu_type,
  input  logic                     csr,
  input  logic                     ifence,
  input  logic [31:0]              pc_fe,
  // writeback
  input  logic                     wb_valid,
  input  logic [`CB_TAG_W-1:0]     wb_tag,
  input  ooo_core_pkg::exc_cause_t wb_cause,
  // busy levels
  input  logic                     busy_du,
  input  logic                     busy_ls,
  input  logic                     i_mem_busy,
  // control flow and privilege
  input  logic                     mispredict,
  input  logic                     intr_req,
  input  logic                     insert_pc,
  output logic                     pc_en,
  output logic                     stall_fetch_decode,
  output logic                     fetch_decode_flush,
  output logic                     decode_execute_flush,
  output logic                     execute_commit_flush,
  output logic                     npc_sel,
  output logic                     pipe_clear,
  output logic                     intr_taken,
  output logic                     wb_enable,
  output logic [`CB_TAG_W-1:0]     issue_tag,
  output logic                     commit_valid,
  output logic [4:0]               commit_rd,
  output logic                     cb_flush,
  output logic [31:0]              epc
);

  hazard_if     hz_if ();
  completion_if cb_if ();

  // decode operands onto the hazard bus
  assign hz_if.rs1          = rs1;
  assign hz_if.rs2          = rs2;
  assign hz_if.rd           = rd;
  assign hz_if.wen          = wen;
  assign hz_if.source_a_sel = source_a_sel;
  assign hz_if.source_b_sel = source_b_sel;

  // retire side out to the core
  assign commit_valid = cb_if.commit_valid;
  assign commit_rd    = cb_if.commit_rd;
  assign cb_flush     = cb_if.flush;
  assign epc          = cb_if.epc;

  reg_scoreboard u_scoreboard (
    .CLK          (CLK),
    .arst_n       (arst_n),
    .hz           (hz_if.scoreboard),
    .commit_valid (cb_if.commit_valid),
    .commit_rd    (cb_if.commit_rd),
    .flush        (cb_if.flush)
  );

  completion_buffer u_completion_buffer (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .cb        (cb_if.cb),
    .rd        (rd),
    .wen       (wen),
    .pc_fe     (pc_fe),
    .wb_valid  (wb_valid),
    .wb_tag    (wb_tag),
    .wb_cause  (wb_cause),
    .issue_tag (issue_tag)
  );

  ooo_hazard_unit u_hazard_unit (
    .hz                   (hz_if.hazard_unit),
    .cb                   (cb_if.hu),
    .dec_valid            (dec_valid),
    .fu_type              (fu_type),
    .csr                  (csr),
    .ifence               (ifence),
    .busy_du              (busy_du),
    .busy_ls              (busy_ls),
    .i_mem_busy           (i_mem_busy),
    .mispredict           (mispredict),
    .intr_req             (intr_req),
    .insert_pc            (insert_pc),
    .pc_en                (pc_en),
    .stall_fetch_decode   (stall_fetch_decode),
    .fetch_decode_flush   (fetch_decode_flush),
    .decode_execute_flush (decode_execute_flush),
    .execute_commit_flush (execute_commit_flush),
    .npc_sel              (npc_sel),
    .pipe_clear           (pipe_clear),
    .intr_taken           (intr_taken),
    .wb_enable            (wb_enable)
  );

endmodule

//--- tb_hazard_ctrl.sv
`include "hazard_ctrl_settings.svh"

module tb_hazard_ctrl;
  import ooo_core_pkg::*;

  localparam int PERIOD       = 4;
  localparam int RESET_CYCLES = 5;
  localparam int WAIT_LIMIT   = 40;
  // per-test budget in cycles
  localparam int TEST_CYCLES  = 200;
  localparam int NUM_TESTS    = 5;
  localparam int RUN_CYCLES   = RESET_CYCLES + NUM_TESTS * TEST_CYCLES + 50;

  logic                 CLK;
  logic                 arst_n;
  logic                 dec_valid;
  logic [4:0]           rs1;
  logic [4:0]           rs2;
  logic [4:0]           rd;
  logic                 wen;
  logic [1:0]           source_a_sel;
  logic [1:0]           source_b_sel;
  fu_type_t             fu_type;
  logic                 csr;
  logic                 ifence;
  logic [31:0]          pc_fe;
  logic                 wb_valid;
  logic [`CB_TAG_W-1:0] wb_tag;
  exc_cause_t           wb_cause;
  logic                 busy_du;
  logic                 busy_ls;
  logic                 i_mem_busy;
  logic                 mispredict;
  logic                 intr_req;
  logic                 insert_pc;
  logic                 pc_en;
  logic                 stall_fetch_decode;
  logic                 fetch_decode_flush;
  logic                 decode_execute_flush;
  logic                 execute_commit_flush;
  logic                 npc_sel;
  logic                 pipe_clear;
  logic                 intr_taken;
  logic                 wb_enable;
  logic [`CB_TAG_W-1:0] issue_tag;
  logic                 commit_valid;
  logic [4:0]           commit_rd;
  logic                 cb_flush;
  logic [31:0]          epc;

  int    seed;
  int    errors;
  int    errors_at_start;
  int    tests_run;
  int    tests_failed;
  string test_name;
  logic [31:0] next_pc;

  hazard_ctrl_top i_hazard_ctrl_top (.*);

  initial CLK = 1'b0;
  always #(PERIOD / 2) CLK = ~CLK;

  // reference model, one slot per in-flight instruction in dispatch order
  typedef struct packed {
    logic [`CB_TAG_W-1:0] tag;
    logic [4:0]           rd;
    logic                 wen;
    logic [31:0]          pc;
    logic                 done;
    exc_cause_t           cause;
  } slot_t;

  slot_t                rob [$];
  logic [`NUM_REGS-1:0] pend;
  logic [`CB_TAG_W-1:0] m_tail;
  int                   m_cnt;
  logic                 head_valid;
  slot_t                head_slot;

  logic       exp_commit;
  logic [4:0] exp_commit_rd;
  logic       exp_flush;
  logic       raw;
  logic       unit_busy;
  logic       drain_wait;
  logic       irq;
  logic       exp_npc;
  logic       exp_intr_taken;
  logic       exp_stall;
  logic       exp_pc_en;
  logic       exp_fd_flush;
  logic       exp_de_flush;
  logic       exp_ec_flush;
  logic       exp_pipe_clear;
  logic       exp_wb_enable;
  logic       exp_dispatch;

  always_comb begin
    exp_commit    = head_valid && head_slot.done && (head_slot.cause == none);
    exp_flush     = head_valid && head_slot.done && (head_slot.cause != none);
    exp_commit_rd = head_slot.wen ? head_slot.rd : 5'd0;
    // only register-file operands wait on a writer
    raw = dec_valid && (((source_a_sel < 2'd2) && pend[rs1]) ||
                        ((source_b_sel < 2'd2) && pend[rs2]) || (wen && pend[rd]));
    unit_busy = dec_valid && (((fu_type == DIV_S) && busy_du) ||
                              ((fu_type == LOADSTORE_S) && busy_ls));
    // stores carry select 1 on operand a
    drain_wait = dec_valid && (m_cnt != 0) &&
                 (ifence || ((fu_type == LOADSTORE_S) && (source_a_sel == 2'd1)));
    irq            = intr_req && !exp_flush;
    exp_intr_taken = irq && (m_cnt == 0);
    exp_npc        = mispredict && !exp_flush;
    exp_stall = irq || csr || raw || unit_busy || drain_wait || (m_cnt == `CB_DEPTH) ||
                (i_mem_busy && (exp_npc || csr || insert_pc || exp_intr_taken));
    exp_pc_en      = !(exp_stall || i_mem_busy);
    exp_fd_flush   = exp_npc || insert_pc || csr || exp_flush;
    exp_de_flush   = !i_mem_busy && (exp_npc || insert_pc || exp_flush);
    exp_ec_flush   = csr || exp_flush;
    exp_pipe_clear = !i_mem_busy && (irq ? (m_cnt == 0) : exp_flush);
    // writeback enable drops on a decode stall or a redirect
    exp_wb_enable  = !exp_stall && !exp_npc;
    exp_dispatch   = dec_valid && !exp_stall;
  end

  always @(posedge CLK or negedge arst_n) begin : model_update
    logic       take_flush;
    logic       take_commit;
    logic       take_dispatch;
    logic [4:0] retire_rd;
    slot_t      s;
    // decisions come from the state before this edge
    take_flush    = exp_flush;
    take_commit   = exp_commit;
    take_dispatch = exp_dispatch;
    retire_rd     = exp_commit_rd;
    if (!arst_n || take_flush) begin
      rob.delete();
      pend   = '0;
      m_tail = '0;
    end else begin
      if (wb_valid) begin
        for (int i = 0; i < rob.size(); i++) begin
          if (rob[i].tag == wb_tag) begin
            s       = rob[i];
            s.done  = 1'b1;
            s.cause = wb_cause;
            rob[i]  = s;
          end
        end
      end
      if (take_commit) begin
        pend[retire_rd] = 1'b0;
        rob.delete(0);
      end
      if (take_dispatch) begin
        s = '{tag: m_tail, rd: rd, wen: wen, pc: pc_fe, done: 1'b0, cause: none};
        rob.push_back(s);
        if (wen && (rd != 5'd0)) begin
          pend[rd] = 1'b1;
        end
        m_tail = m_tail + 1'b1;
      end
    end
    m_cnt      = rob.size();
    head_valid = (m_cnt != 0);
    head_slot  = head_valid ? rob[0] : '0;
  end

  task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    errors++;
    $display("FAILED %s: %s expected %0h actual %0h", test_name, sig, exp_v, act_v);
  endtask

  a_stall: assert property (@(posedge CLK) disable iff (!arst_n)
    stall_fetch_decode == exp_stall)
    else report_mismatch("stall_fetch_decode", $sampled(exp_stall), $sampled(stall_fetch_decode));
  a_pc_en: assert property (@(posedge CLK) disable iff (!arst_n) pc_en == exp_pc_en)
    else report_mismatch("pc_en", $sampled(exp_pc_en), $sampled(pc_en));
  a_issue_tag: assert property (@(posedge CLK) disable iff (!arst_n) issue_tag == m_tail)
    else report_mismatch("issue_tag", $sampled(m_tail), $sampled(issue_tag));
  a_commit: assert property (@(posedge CLK) disable iff (!arst_n) commit_valid == exp_commit)
    else report_mismatch("commit_valid", $sampled(exp_commit), $sampled(commit_valid));
  // retire order must follow dispatch order
  a_commit_rd: assert property (@(posedge CLK) disable iff (!arst_n)
    exp_commit |-> commit_rd == exp_commit_rd)
    else report_mismatch("commit_rd", $sampled(exp_commit_rd), $sampled(commit_rd));
  a_flush: assert property (@(posedge CLK) disable iff (!arst_n) cb_flush == exp_flush)
    else report_mismatch("cb_flush", $sampled(exp_flush), $sampled(cb_flush));
  a_epc: assert property (@(posedge CLK) disable iff (!arst_n) exp_flush |-> epc == head_slot.pc)
    else report_mismatch("epc", $sampled(head_slot.pc), $sampled(epc));
  a_npc: assert property (@(posedge CLK) disable iff (!arst_n) npc_sel == exp_npc)
    else report_mismatch("npc_sel", $sampled(exp_npc), $sampled(npc_sel));
  a_fd_flush: assert property (@(posedge CLK) disable iff (!arst_n)
    fetch_decode_flush == exp_fd_flush)
    else report_mismatch("fetch_decode_flush", $sampled(exp_fd_flush),
                         $sampled(fetch_decode_flush));
  a_de_flush: assert property (@(posedge CLK) disable iff (!arst_n)
    decode_execute_flush == exp_de_flush)
    else report_mismatch("decode_execute_flush", $sampled(exp_de_flush),
                         $sampled(decode_execute_flush));
  a_ec_flush: assert property (@(posedge CLK) disable iff (!arst_n)
    execute_commit_flush == exp_ec_flush)
    else report_mismatch("execute_commit_flush", $sampled(exp_ec_flush),
                         $sampled(execute_commit_flush));
  a_intr: assert property (@(posedge CLK) disable iff (!arst_n) intr_taken == exp_intr_taken)
    else report_mismatch("intr_taken", $sampled(exp_intr_taken), $sampled(intr_taken));
  a_pipe_clear: assert property (@(posedge CLK) disable iff (!arst_n)
    pipe_clear == exp_pipe_clear)
    else report_mismatch("pipe_clear", $sampled(exp_pipe_clear), $sampled(pipe_clear));
  a_wb_enable: assert property (@(posedge CLK) disable iff (!arst_n)
    wb_enable == exp_wb_enable)
    else report_mismatch("wb_enable", $sampled(exp_wb_enable), $sampled(wb_enable));

  // register 1..31
  function automatic logic [4:0] rand_reg();
    int r;
    r = $random(seed);
    return 5'(1 + ((r & 32'h7fff_ffff) % 31));
  endfunction

  function automatic logic level_high(input string what);
    return (what == "cb_flush") ? cb_flush : intr_taken;
  endfunction

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge CLK);
      #1;
    end
  endtask

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == errors_at_start) begin
      $display("%-18s ok", test_name);
    end else begin
      tests_failed++;
      $display("%-18s %0d mismatches", test_name, errors - errors_at_start);
    end
  endtask

  task automatic present(input logic [4:0] d_rd, input logic d_wen, input logic [4:0] d_rs1,
                         input logic [4:0] d_rs2, input logic [1:0] sel_a,
                         input logic [1:0] sel_b, input fu_type_t fu);
    rd           = d_rd;
    wen          = d_wen;
    rs1          = d_rs1;
    rs2          = d_rs2;
    source_a_sel = sel_a;
    source_b_sel = sel_b;
    fu_type      = fu;
    csr          = 1'b0;
    ifence       = 1'b0;
    pc_fe        = next_pc;
    next_pc      = next_pc + 32'd4;
    dec_valid    = 1'b1;
  endtask

  // hold decode until accepted, hand back the tag it got
  task automatic accept_decode(output logic [`CB_TAG_W-1:0] tag);
    int n;
    n = 0;
    @(negedge CLK);
    while (stall_fetch_decode && (n < WAIT_LIMIT)) begin
      @(negedge CLK);
      n++;
    end
    if (stall_fetch_decode) begin
      errors++;
      $display("%s: decode was never accepted", test_name);
    end
    tag = issue_tag;
    @(posedge CLK);
    #1;
    dec_valid = 1'b0;
  endtask

  task automatic dispatch_one(input logic [4:0] d_rd, input logic d_wen, input fu_type_t fu,
                              output logic [`CB_TAG_W-1:0] tag);
    present(d_rd, d_wen, rand_reg(), rand_reg(), 2'd2, 2'd3, fu);
    accept_decode(tag);
  endtask

  task automatic write_back(input logic [`CB_TAG_W-1:0] tag, input exc_cause_t cause);
    wb_valid = 1'b1;
    wb_tag   = tag;
    wb_cause = cause;
    @(posedge CLK);
    #1;
    wb_valid = 1'b0;
    wb_cause = none;
  endtask

  task automatic await_level(input string what);
    int n;
    n = 0;
    while (!level_high(what) && (n < WAIT_LIMIT)) begin
      @(negedge CLK);
      n++;
    end
    if (!level_high(what)) begin
      errors++;
      $display("%s: %s never went high", test_name, what);
    end
    @(posedge CLK);
    #1;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while ((m_cnt != 0) && (n < WAIT_LIMIT)) begin
      idle(1);
      n++;
    end
    if (m_cnt != 0) begin
      errors++;
      $display("%s: completion buffer did not drain", test_name);
    end
  endtask

  task automatic raw_stall_test();
    logic [`CB_TAG_W-1:0] t0;
    logic [`CB_TAG_W-1:0] t1;
    logic [`CB_TAG_W-1:0] t2;
    logic [`CB_TAG_W-1:0] t3;
    logic [4:0]           r;
    begin_test("raw_stall");
    r = rand_reg();
    dispatch_one(r, 1'b1, ARITH_S, t0);
    // reader of r through the register file, stalls
    present(5'd0, 1'b0, r, 5'd0, 2'd0, 2'd1, ARITH_S);
    idle(3);
    // second operand reads r through select 1
    source_a_sel = 2'd2;
    rs2          = r;
    idle(2);
    // both operands off the register file, no wait
    source_b_sel = 2'd3;
    accept_decode(t1);
    dispatch_one(5'd0, 1'b1, ARITH_S, t2);
    present(5'd0, 1'b0, 5'd0, 5'd0, 2'd0, 2'd1, ARITH_S);
    accept_decode(t3);
    write_back(t0, none);
    write_back(t1, none);
    write_back(t2, none);
    write_back(t3, none);
    drain();
    end_test();
  endtask

  task automatic in_order_test();
    logic [`CB_TAG_W-1:0] tags [6];
    logic [`CB_TAG_W-1:0] tmp;
    int                   base;
    int                   j;
    begin_test("in_order_commit");
    base = rand_reg() - 1;
    // step 5 over 31 registers keeps destinations distinct
    for (int i = 0; i < 6; i++) begin
      dispatch_one(5'(1 + ((base + 5 * i) % 31)), 1'b1, ARITH_S, tags[i]);
    end
    for (int i = 5; i > 0; i--) begin
      j       = ($random(seed) & 32'h7fff_ffff) % (i + 1);
      tmp     = tags[i];
      tags[i] = tags[j];
      tags[j] = tmp;
    end
    for (int i = 0; i < 6; i++) begin
      write_back(tags[i], none);
    end
    drain();
    end_test();
  endtask

  task automatic back_pressure_test();
    logic [`CB_TAG_W-1:0] tags [`CB_DEPTH];
    logic [`CB_TAG_W-1:0] t;
    logic [`CB_TAG_W-1:0] a;
    begin_test("back_pressure");
    for (int i = 0; i < `CB_DEPTH; i++) begin
      dispatch_one(5'd0, 1'b0, ARITH_S, tags[i]);
    end
    // buffer full, this one must wait
    present(5'd0, 1'b0, 5'd0, 5'd0, 2'd2, 2'd2, ARITH_S);
    idle(4);
    dec_valid = 1'b0;
    // store waits for every older entry to retire
    present(5'd0, 1'b0, 5'd0, 5'd0, 2'd1, 2'd0, LOADSTORE_S);
    for (int i = 0; i < `CB_DEPTH; i++) begin
      write_back(tags[i], none);
    end
    accept_decode(t);
    write_back(t, none);
    drain();
    dispatch_one(5'd0, 1'b0, ARITH_S, a);
    present(5'd0, 1'b0, 5'd0, 5'd0, 2'd2, 2'd2, ARITH_S);
    ifence = 1'b1;
    idle(2);
    write_back(a, none);
    accept_decode(t);
    ifence = 1'b0;
    write_back(t, none);
    drain();
    end_test();
  endtask

  task automatic precise_exception_test();
    logic [`CB_TAG_W-1:0] tags [4];
    begin_test("precise_exception");
    for (int i = 0; i < 4; i++) begin
      dispatch_one(5'(6 + i), 1'b1, ARITH_S, tags[i]);
    end
    // middle entry faults, stays quiet behind older work
    write_back(tags[2], illegal_insn);
    idle(2);
    write_back(tags[0], none);
    write_back(tags[1], none);
    await_level("cb_flush");
    idle(2);
    end_test();
  endtask

  task automatic control_intr_test();
    logic [`CB_TAG_W-1:0] a;
    logic [`CB_TAG_W-1:0] b;
    begin_test("control_intr");
    mispredict = 1'b1;
    idle(1);
    // redirect held off by an outstanding fetch
    i_mem_busy = 1'b1;
    idle(1);
    mispredict = 1'b0;
    i_mem_busy = 1'b0;
    dispatch_one(5'd10, 1'b1, ARITH_S, a);
    intr_req = 1'b1;
    idle(3);
    write_back(a, none);
    await_level("intr_taken");
    intr_req = 1'b0;
    present(5'd11, 1'b1, 5'd0, 5'd0, 2'd2, 2'd2, DIV_S);
    busy_du = 1'b1;
    idle(3);
    busy_du = 1'b0;
    accept_decode(b);
    write_back(b, none);
    csr = 1'b1;
    idle(2);
    csr = 1'b0;
    insert_pc = 1'b1;
    idle(1);
    insert_pc = 1'b0;
    drain();
    end_test();
  endtask

  initial begin
    seed         = 35;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_name    = "reset";
    next_pc      = 32'h0000_1000;
    arst_n       = 1'b0;
    dec_valid    = 1'b0;
    rs1          = '0;
    rs2          = '0;
    rd           = '0;
    wen          = 1'b0;
    source_a_sel = 2'd2;
    source_b_sel = 2'd2;
    fu_type      = ARITH_S;
    csr          = 1'b0;
    ifence       = 1'b0;
    pc_fe        = '0;
    wb_valid     = 1'b0;
    wb_tag       = '0;
    wb_cause     = none;
    busy_du      = 1'b0;
    busy_ls      = 1'b0;
    i_mem_busy   = 1'b0;
    mispredict   = 1'b0;
    intr_req     = 1'b0;
    insert_pc    = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1;
    arst_n = 1'b1;
    idle(2);
    raw_stall_test();
    in_order_test();
    back_pressure_test();
    precise_exception_test();
    control_intr_test();
    $display("tests run %0d, tests with errors %0d, mismatches %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // watchdog over the summed test budgets
  initial begin
    #(RUN_CYCLES * PERIOD);
    $display("watchdog expired after %0d cycles, run did not complete", RUN_CYCLES);
    $display("test failed");
    $finish;
  end

endmodule

//--- hazard_ctrl_top.f
+incdir+.
ooo_core_pkg.sv
hazard_if.sv
completion_if.sv
reg_scoreboard.sv
completion_buffer.sv
ooo_hazard_unit.sv
hazard_ctrl_top.sv
tb_hazard_ctrl.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_hazard_ctrl \
  -f hazard_ctrl_top.f -o sim_hazard_ctrl
./obj_dir/sim_hazard_ctrl | tee sim.log
if grep -q "^test passed$" sim.log; then
  exit 0
fi
exit 1
